/* rtl/shell_axi_pkg.sv */
//------------------------------------------------
// pcis channel widths of the shell interface
// single-beat use only, len is always zero
//------------------------------------------------
`default_nettype none

package shell_axi_pkg;

   //------------------------------------------------
   // widths
   //------------------------------------------------
   localparam int AXI_ADDR_W = 64;
   localparam int AXI_DATA_W = 512;
   localparam int AXI_STRB_W = AXI_DATA_W / 8;
   localparam int AXI_ID_W   = 5;
   localparam int AXI_LEN_W  = 8;
   localparam int AXI_RESP_W = 2;
   // number of 32-bit words across the data bus
   localparam int AXI_LANES  = AXI_DATA_W / 32;

   typedef logic [AXI_ADDR_W-1:0]        axi_addr_t;
   typedef logic [AXI_DATA_W-1:0]        axi_data_t;
   typedef logic [AXI_STRB_W-1:0]        axi_strb_t;
   typedef logic [AXI_ID_W-1:0]          axi_id_t;
   typedef logic [AXI_LEN_W-1:0]         axi_len_t;
   typedef logic [AXI_RESP_W-1:0]        axi_resp_t;
   typedef logic [$clog2(AXI_LANES)-1:0] lane_idx_t;

   localparam axi_resp_t AXI_RESP_OKAY = 2'b00;

   //------------------------------------------------
   // channel payloads
   //------------------------------------------------
   // shared by AW and AR
   typedef struct packed {
      axi_addr_t addr;
      axi_id_t   id;
      axi_len_t  len;
   } axi_ax_t;

   typedef struct packed {
      axi_data_t data;
      axi_strb_t strb;
      logic      last;
   } axi_w_t;

   typedef struct packed {
      axi_id_t   id;
      axi_resp_t resp;
   } axi_b_t;

   typedef struct packed {
      axi_data_t data;
      axi_id_t   id;
      axi_resp_t resp;
      logic      last;
   } axi_r_t;

endpackage

`default_nettype wire

/* rtl/shell_host_pkg.sv */
//------------------------------------------------
// host side is a 32-bit Wishbone classic port
// byte addressed, one access at a time
//------------------------------------------------
`default_nettype none

package shell_host_pkg;

   localparam int HOST_ADDR_W = 32;
   localparam int HOST_DATA_W = 32;
   localparam int HOST_SEL_W  = HOST_DATA_W / 8;

   typedef logic [HOST_ADDR_W-1:0] host_addr_t;
   typedef logic [HOST_DATA_W-1:0] host_data_t;
   typedef logic [HOST_SEL_W-1:0]  host_sel_t;

   // request as latched by the controller
   typedef struct packed {
      host_addr_t adr;
      host_data_t dat;
      host_sel_t  sel;
      logic       we;
   } wb_req_t;

endpackage

`default_nettype wire

/* rtl/axi_wr_master.sv */
//------------------------------------------------
// one single-beat write per start, AW and W issued
// together and accepted in any order, then B
//------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module axi_wr_master #(
   parameter shell_axi_pkg::axi_id_t WR_ID = 2
) (
   input  logic                    clk_out,
   input  logic                    arst_n_i,
   input  logic                    start_i,
   input  shell_host_pkg::wb_req_t req_i,
   output shell_axi_pkg::axi_ax_t  aw_o,
   output logic                    aw_valid_o,
   input  logic                    aw_ready_i,
   output shell_axi_pkg::axi_w_t   w_o,
   output logic                    w_valid_o,
   input  logic                    w_ready_i,
   input  shell_axi_pkg::axi_b_t   b_i,
   input  logic                    b_valid_i,
   output logic                    b_ready_o,
   output logic                    done_o,
   output logic                    err_o
);

   import shell_axi_pkg::*;
   import shell_host_pkg::*;

   typedef enum logic [2:0] {
      WR_IDLE,
      WR_BOTH,
      WR_ADDR,
      WR_DATA,
      WR_RESP
   } wr_state_e;

   wr_state_e state_q;
   wr_state_e state_d;
   lane_idx_t wr_lane;
   logic      aw_hs;
   logic      w_hs;
   logic      b_hs;

   // word lane inside the 64-byte beat
   assign wr_lane = req_i.adr[2 +: $bits(lane_idx_t)];

   assign aw_hs = aw_valid_o && aw_ready_i;
   assign w_hs  = w_valid_o && w_ready_i;
   assign b_hs  = b_ready_o && b_valid_i;

   assign aw_valid_o = (state_q == WR_BOTH) || (state_q == WR_ADDR);
   assign w_valid_o  = (state_q == WR_BOTH) || (state_q == WR_DATA);
   assign b_ready_o  = (state_q == WR_RESP);

   //------------------------------------------------
   // handshake tracking
   //------------------------------------------------
   always_comb begin
      state_d = state_q;
      unique case (state_q)
         WR_IDLE: begin
            if (start_i) begin
               state_d = WR_BOTH;
            end
         end
         WR_BOTH: begin
            if (aw_hs && w_hs) begin
               state_d = WR_RESP;
            end else if (aw_hs) begin
               state_d = WR_DATA;
            end else if (w_hs) begin
               state_d = WR_ADDR;
            end
         end
         WR_ADDR: begin
            if (aw_hs) begin
               state_d = WR_RESP;
            end
         end
         WR_DATA: begin
            if (w_hs) begin
               state_d = WR_RESP;
            end
         end
         WR_RESP: begin
            if (b_hs) begin
               state_d = WR_IDLE;
            end
         end
         default: state_d = WR_IDLE;
      endcase
   end

   always_ff @(posedge clk_out or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q <= WR_IDLE;
         done_o  <= 1'b0;
         err_o   <= 1'b0;
      end else begin
         state_q <= state_d;
         done_o  <= b_hs;
         err_o   <= b_hs && (b_i.resp != AXI_RESP_OKAY);
      end
   end

   // payload only loads from idle, so it holds through back-pressure
   always_ff @(posedge clk_out) begin
      if ((state_q == WR_IDLE) && start_i) begin
         aw_o.addr <= axi_addr_t'({req_i.adr[HOST_ADDR_W-1:2], 2'b00});
         aw_o.id   <= WR_ID;
         aw_o.len  <= '0;
         // same word in every lane, strobe picks the one that counts
         w_o.data  <= {AXI_LANES{req_i.dat}};
         w_o.strb  <= axi_strb_t'(req_i.sel) << {wr_lane, 2'b00};
         w_o.last  <= 1'b1;
      end
   end

   a_aw_stable : assert property (
      @(posedge clk_out) disable iff (!arst_n_i)
      aw_valid_o && !aw_ready_i |=> aw_valid_o && $stable(aw_o)
   ) else $error("AW payload changed before handshake");

endmodule

`default_nettype wire

/* rtl/axi_rd_master.sv */
//------------------------------------------------
// one single-beat read per start
// returns the 32-bit lane picked by address 5:2
//------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module axi_rd_master #(
   parameter shell_axi_pkg::axi_id_t RD_ID = 1
) (
   input  logic                       clk_out,
   input  logic                       arst_n_i,
   input  logic                       start_i,
   input  shell_host_pkg::wb_req_t    req_i,
   output shell_axi_pkg::axi_ax_t     ar_o,
   output logic                       ar_valid_o,
   input  logic                       ar_ready_i,
   input  shell_axi_pkg::axi_r_t      r_i,
   input  logic                       r_valid_i,
   output logic                       r_ready_o,
   output logic                       done_o,
   output logic                       err_o,
   output shell_host_pkg::host_data_t rdata_o
);

   import shell_axi_pkg::*;
   import shell_host_pkg::*;

   typedef enum logic [1:0] {
      RD_IDLE,
      RD_ADDR,
      RD_DATA
   } rd_state_e;

   rd_state_e state_q;
   lane_idx_t rd_lane_q;
   logic      ar_hs;
   logic      r_hs;

   assign ar_hs = ar_valid_o && ar_ready_i;
   assign r_hs  = r_ready_o && r_valid_i;

   assign ar_valid_o = (state_q == RD_ADDR);
   assign r_ready_o  = (state_q == RD_DATA);

   always_ff @(posedge clk_out or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q <= RD_IDLE;
         done_o  <= 1'b0;
         err_o   <= 1'b0;
      end else begin
         done_o <= r_hs;
         err_o  <= r_hs && (r_i.resp != AXI_RESP_OKAY);
         unique case (state_q)
            RD_IDLE: if (start_i) state_q <= RD_ADDR;
            RD_ADDR: if (ar_hs) state_q <= RD_DATA;
            RD_DATA: if (r_hs) state_q <= RD_IDLE;
            default: state_q <= RD_IDLE;
         endcase
      end
   end

   //------------------------------------------------
   // request and read data capture
   //------------------------------------------------
   always_ff @(posedge clk_out) begin
      if ((state_q == RD_IDLE) && start_i) begin
         ar_o.addr <= axi_addr_t'({req_i.adr[HOST_ADDR_W-1:2], 2'b00});
         ar_o.id   <= RD_ID;
         ar_o.len  <= '0;
         rd_lane_q <= req_i.adr[2 +: $bits(lane_idx_t)];
      end
      if (r_hs) begin
         rdata_o <= r_i.data[rd_lane_q*HOST_DATA_W +: HOST_DATA_W];
      end
   end

   // len is zero, so the CL must close the burst on its first beat
   a_rlast : assert property (
      @(posedge clk_out) disable iff (!arst_n_i)
      r_hs |-> r_i.last
   ) else $error("R beat accepted without rlast");

endmodule

`default_nettype wire

/* rtl/host_access_ctrl.sv */
//------------------------------------------------
// Wishbone classic slave, one access in flight
// misaligned addresses are refused with err
//------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module host_access_ctrl (
   input  logic                       clk_out,
   input  logic                       arst_n_i,
   input  logic                       wb_cyc_i,
   input  logic                       wb_stb_i,
   input  logic                       wb_we_i,
   input  shell_host_pkg::host_addr_t wb_adr_i,
   input  shell_host_pkg::host_data_t wb_dat_i,
   input  shell_host_pkg::host_sel_t  wb_sel_i,
   output shell_host_pkg::host_data_t wb_dat_o,
   output logic                       wb_ack_o,
   output logic                       wb_err_o,
   output shell_host_pkg::wb_req_t    req_o,
   output logic                       wr_start_o,
   output logic                       rd_start_o,
   input  logic                       wr_done_i,
   input  logic                       wr_err_i,
   input  logic                       rd_done_i,
   input  logic                       rd_err_i,
   input  shell_host_pkg::host_data_t rd_data_i
);

   import shell_host_pkg::*;

   typedef enum logic [1:0] {
      CTRL_IDLE,
      CTRL_BUSY,
      CTRL_RESPOND
   } ctrl_state_e;

   ctrl_state_e state_q;
   wb_req_t     req_q;
   logic        misaligned_q;
   logic        req_seen;
   logic        adr_aligned;
   logic        acc_done;
   logic        acc_err;

   assign req_seen    = wb_cyc_i && wb_stb_i && (state_q == CTRL_IDLE);
   assign adr_aligned = (wb_adr_i[1:0] == 2'b00);

   // result of whichever master was started
   assign acc_done = (state_q == CTRL_BUSY) && !misaligned_q &&
                     (req_q.we ? wr_done_i : rd_done_i);
   assign acc_err  = req_q.we ? wr_err_i : rd_err_i;

   always_ff @(posedge clk_out or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q      <= CTRL_IDLE;
         misaligned_q <= 1'b0;
         wr_start_o   <= 1'b0;
         rd_start_o   <= 1'b0;
      end else begin
         wr_start_o <= req_seen && adr_aligned && wb_we_i;
         rd_start_o <= req_seen && adr_aligned && !wb_we_i;
         unique case (state_q)
            CTRL_IDLE: begin
               if (req_seen) begin
                  state_q      <= CTRL_BUSY;
                  misaligned_q <= !adr_aligned;
               end
            end
            CTRL_BUSY: begin
               if (misaligned_q) begin
                  state_q <= CTRL_RESPOND;
               end else if (acc_done) begin
                  state_q <= CTRL_IDLE;
               end
            end
            CTRL_RESPOND: state_q <= CTRL_IDLE;
            default: state_q <= CTRL_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_out) begin
      if (req_seen) begin
         req_q.adr <= wb_adr_i;
         req_q.dat <= wb_dat_i;
         req_q.sel <= wb_sel_i;
         req_q.we  <= wb_we_i;
      end
   end

   assign req_o = req_q;

   //------------------------------------------------
   // host response
   //------------------------------------------------
   assign wb_ack_o = acc_done && !acc_err;
   assign wb_err_o = (acc_done && acc_err) || (state_q == CTRL_RESPOND);
   // read data only shown with a read ack
   assign wb_dat_o = (wb_ack_o && !req_q.we) ? rd_data_i : '0;

   // a master may only finish the access that it was started for
   a_done_in_access : assert property (
      @(posedge clk_out) disable iff (!arst_n_i)
      (wr_done_i || rd_done_i) |-> (state_q == CTRL_BUSY) && !misaligned_q &&
                                   (req_q.we ? !rd_done_i : !wr_done_i)
   ) else $error("master done outside its access");

endmodule

`default_nettype wire

/* rtl/shell_pcis_bridge.sv */
//------------------------------------------------
// host register access to the pcis AXI4 port
// WR_ID and RD_ID set the AXI IDs of each path
//------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module shell_pcis_bridge #(
   parameter shell_axi_pkg::axi_id_t WR_ID = 2,
   parameter shell_axi_pkg::axi_id_t RD_ID = 1
) (
   input  logic                       clk_out,
   input  logic                       arst_n_i,
   // host side
   input  logic                       wb_cyc_i,
   input  logic                       wb_stb_i,
   input  logic                       wb_we_i,
   input  shell_host_pkg::host_addr_t wb_adr_i,
   input  shell_host_pkg::host_data_t wb_dat_i,
   input  shell_host_pkg::host_sel_t  wb_sel_i,
   output shell_host_pkg::host_data_t wb_dat_o,
   output logic                       wb_ack_o,
   output logic                       wb_err_o,
   // write channels
   output shell_axi_pkg::axi_ax_t     pcis_aw_o,
   output logic                       pcis_awvalid_o,
   input  logic                       pcis_awready_i,
   output shell_axi_pkg::axi_w_t      pcis_w_o,
   output logic                       pcis_wvalid_o,
   input  logic                       pcis_wready_i,
   input  shell_axi_pkg::axi_b_t      pcis_b_i,
   input  logic                       pcis_bvalid_i,
   output logic                       pcis_bready_o,
   // read channels
   output shell_axi_pkg::axi_ax_t     pcis_ar_o,
   output logic                       pcis_arvalid_o,
   input  logic                       pcis_arready_i,
   input  shell_axi_pkg::axi_r_t      pcis_r_i,
   input  logic                       pcis_rvalid_i,
   output logic                       pcis_rready_o
);

   import shell_host_pkg::*;

   wb_req_t    req;
   logic       wr_start;
   logic       wr_done;
   logic       wr_err;
   logic       rd_start;
   logic       rd_done;
   logic       rd_err;
   host_data_t rd_data;

   host_access_ctrl u_ctrl (
      .clk_out    (clk_out),
      .arst_n_i   (arst_n_i),
      .wb_cyc_i   (wb_cyc_i),
      .wb_stb_i   (wb_stb_i),
      .wb_we_i    (wb_we_i),
      .wb_adr_i   (wb_adr_i),
      .wb_dat_i   (wb_dat_i),
      .wb_sel_i   (wb_sel_i),
      .wb_dat_o   (wb_dat_o),
      .wb_ack_o   (wb_ack_o),
      .wb_err_o   (wb_err_o),
      .req_o      (req),
      .wr_start_o (wr_start),
      .rd_start_o (rd_start),
      .wr_done_i  (wr_done),
      .wr_err_i   (wr_err),
      .rd_done_i  (rd_done),
      .rd_err_i   (rd_err),
      .rd_data_i  (rd_data)
   );

   axi_wr_master #(
      .WR_ID (WR_ID)
   ) u_wr (
      .clk_out    (clk_out),
      .arst_n_i   (arst_n_i),
      .start_i    (wr_start),
      .req_i      (req),
      .aw_o       (pcis_aw_o),
      .aw_valid_o (pcis_awvalid_o),
      .aw_ready_i (pcis_awready_i),
      .w_o        (pcis_w_o),
      .w_valid_o  (pcis_wvalid_o),
      .w_ready_i  (pcis_wready_i),
      .b_i        (pcis_b_i),
      .b_valid_i  (pcis_bvalid_i),
      .b_ready_o  (pcis_bready_o),
      .done_o     (wr_done),
      .err_o      (wr_err)
   );

   axi_rd_master #(
      .RD_ID (RD_ID)
   ) u_rd (
      .clk_out    (clk_out),
      .arst_n_i   (arst_n_i),
      .start_i    (rd_start),
      .req_i      (req),
      .ar_o       (pcis_ar_o),
      .ar_valid_o (pcis_arvalid_o),
      .ar_ready_i (pcis_arready_i),
      .r_i        (pcis_r_i),
      .r_valid_i  (pcis_rvalid_i),
      .r_ready_o  (pcis_rready_o),
      .done_o     (rd_done),
      .err_o      (rd_err),
      .rdata_o    (rd_data)
   );

endmodule

`default_nettype wire

/* bench/cl_axi_responder.sv */
//------------------------------------------------
// custom logic model, 256-word memory on addr 9:2
// SLVERR for addr bit 31, random ready delays
//------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module cl_axi_responder #(
   parameter int SEED = 1
) (
   input  logic                   clk_out,
   input  logic                   arst_n_i,
   input  shell_axi_pkg::axi_ax_t aw_i,
   input  logic                   aw_valid_i,
   output logic                   aw_ready_o,
   input  shell_axi_pkg::axi_w_t  w_i,
   input  logic                   w_valid_i,
   output logic                   w_ready_o,
   output shell_axi_pkg::axi_b_t  b_o,
   output logic                   b_valid_o,
   input  logic                   b_ready_i,
   input  shell_axi_pkg::axi_ax_t ar_i,
   input  logic                   ar_valid_i,
   output logic                   ar_ready_o,
   output shell_axi_pkg::axi_r_t  r_o,
   output logic                   r_valid_o,
   input  logic                   r_ready_i
);

   import shell_axi_pkg::*;

   logic [31:0] mem [0:255];
   integer      seed;
   axi_ax_t     aw_q;
   axi_ax_t     ar_q;
   axi_w_t      w_q;
   logic        have_aw;
   logic        have_w;
   logic        have_ar;
   logic        b_done;
   logic        r_done;
   int          lane;

   initial begin
      seed = SEED;
      for (int i = 0; i < 256; i++) begin
         mem[i] = '0;
      end
      {aw_ready_o, w_ready_o, b_valid_o, ar_ready_o, r_valid_o} = '0;
      b_o = '0;
      r_o = '0;
      {have_aw, have_w, have_ar} = '0;
   end

   always begin
      @(posedge clk_out);
      b_done = b_valid_o && b_ready_i;
      r_done = r_valid_o && r_ready_i;
      if (aw_valid_i && aw_ready_o) begin
         aw_q    = aw_i;
         have_aw = 1'b1;
      end
      if (w_valid_i && w_ready_o) begin
         w_q    = w_i;
         have_w = 1'b1;
      end
      if (ar_valid_i && ar_ready_o) begin
         ar_q    = ar_i;
         have_ar = 1'b1;
      end
      #1;
      if (!arst_n_i) begin
         {aw_ready_o, w_ready_o, b_valid_o, ar_ready_o, r_valid_o} = '0;
         {have_aw, have_w, have_ar} = '0;
      end else begin
         if (b_done) b_valid_o = 1'b0;
         if (r_done) r_valid_o = 1'b0;
         // write response once both beats are in
         if (have_aw && have_w && !b_valid_o && (($random(seed) & 3) != 0)) begin
            lane = int'(aw_q.addr[5:2]);
            if (!aw_q.addr[31]) begin
               for (int b = 0; b < 4; b++) begin
                  if (w_q.strb[lane*4 + b]) begin
                     mem[aw_q.addr[9:2]][b*8 +: 8] = w_q.data[lane*32 + b*8 +: 8];
                  end
               end
            end
            b_o.id    = aw_q.id;
            b_o.resp  = aw_q.addr[31] ? 2'b10 : AXI_RESP_OKAY;
            b_valid_o = 1'b1;
            have_aw   = 1'b0;
            have_w    = 1'b0;
         end
         if (have_ar && !r_valid_o && (($random(seed) & 3) != 0)) begin
            lane      = int'(ar_q.addr[5:2]);
            r_o       = '0;
            if (!ar_q.addr[31]) begin
               r_o.data[lane*32 +: 32] = mem[ar_q.addr[9:2]];
            end
            r_o.id    = ar_q.id;
            r_o.resp  = ar_q.addr[31] ? 2'b10 : AXI_RESP_OKAY;
            r_o.last  = 1'b1;
            r_valid_o = 1'b1;
            have_ar   = 1'b0;
         end
         aw_ready_o = !have_aw && $random(seed) & 1;
         w_ready_o  = !have_w && $random(seed) & 1;
         ar_ready_o = !have_ar && $random(seed) & 1;
      end
   end

endmodule

`default_nettype wire

/* bench/tb_shell_pcis_bridge.sv */
//------------------------------------------------
// random Wishbone accesses against a word model
// addresses use bits 9:2 and bit 31 (error region)
//------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module tb_shell_pcis_bridge;

   import shell_axi_pkg::*;
   import shell_host_pkg::*;

   localparam axi_id_t WR_ID   = 5'd3;
   localparam axi_id_t RD_ID   = 5'd6;
   localparam int      TIMEOUT = 200;
   localparam int      N_ACC   = 60;

   logic       clk_out;
   logic       arst_n_i;
   logic       wb_cyc_i;
   logic       wb_stb_i;
   logic       wb_we_i;
   host_addr_t wb_adr_i;
   host_data_t wb_dat_i;
   host_sel_t  wb_sel_i;
   host_data_t wb_dat_o;
   logic       wb_ack_o;
   logic       wb_err_o;
   axi_ax_t    aw;
   axi_ax_t    ar;
   axi_w_t     w;
   axi_b_t     b;
   axi_r_t     r;
   logic       awvalid;
   logic       awready;
   logic       wvalid;
   logic       wready;
   logic       bvalid;
   logic       bready;
   logic       arvalid;
   logic       arready;
   logic       rvalid;
   logic       rready;

   integer     seed;
   int         data_errors;
   int         proto_errors;
   int         timeout_errors;
   logic [31:0] model [0:255];
   host_addr_t cur_adr;
   host_data_t cur_dat;
   host_sel_t  cur_sel;
   logic       misaligned_run;
   host_addr_t adr_list [N_ACC];
   axi_ax_t    aw_prev;
   axi_ax_t    ar_prev;
   axi_w_t     w_prev;
   logic       aw_wait;
   logic       ar_wait;
   logic       w_wait;

   shell_pcis_bridge #(.WR_ID(WR_ID), .RD_ID(RD_ID)) uut (
      .clk_out (clk_out), .arst_n_i (arst_n_i),
      .wb_cyc_i (wb_cyc_i), .wb_stb_i (wb_stb_i), .wb_we_i (wb_we_i),
      .wb_adr_i (wb_adr_i), .wb_dat_i (wb_dat_i), .wb_sel_i (wb_sel_i),
      .wb_dat_o (wb_dat_o), .wb_ack_o (wb_ack_o), .wb_err_o (wb_err_o),
      .pcis_aw_o (aw), .pcis_awvalid_o (awvalid), .pcis_awready_i (awready),
      .pcis_w_o (w), .pcis_wvalid_o (wvalid), .pcis_wready_i (wready),
      .pcis_b_i (b), .pcis_bvalid_i (bvalid), .pcis_bready_o (bready),
      .pcis_ar_o (ar), .pcis_arvalid_o (arvalid), .pcis_arready_i (arready),
      .pcis_r_i (r), .pcis_rvalid_i (rvalid), .pcis_rready_o (rready)
   );

   cl_axi_responder #(.SEED(32'ha557_a199)) u_cl (
      .clk_out (clk_out), .arst_n_i (arst_n_i),
      .aw_i (aw), .aw_valid_i (awvalid), .aw_ready_o (awready),
      .w_i (w), .w_valid_i (wvalid), .w_ready_o (wready),
      .b_o (b), .b_valid_o (bvalid), .b_ready_i (bready),
      .ar_i (ar), .ar_valid_i (arvalid), .ar_ready_o (arready),
      .r_o (r), .r_valid_o (rvalid), .r_ready_i (rready)
   );

   initial begin
      clk_out = 1'b0;
      forever #2 clk_out = ~clk_out;
   end

   //------------------------------------------------
   // compare tasks
   //------------------------------------------------
   task automatic compare_data(input string name, input host_data_t got, input host_data_t exp);
      if (got !== exp) begin
         $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
         data_errors++;
      end
   endtask

   task automatic compare_err(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
         proto_errors++;
      end
   endtask

   task automatic compare_ax(input string name, input axi_ax_t got, input axi_ax_t exp);
      if (got !== exp) begin
         $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
         proto_errors++;
      end
   endtask

   task automatic compare_strb(input string name, input axi_strb_t got, input axi_strb_t exp);
      if (got !== exp) begin
         $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
         proto_errors++;
      end
   endtask

   // byte enables of the whole beat, only the addressed word may be set
   function automatic axi_strb_t lane_strobe(input host_addr_t adr, input host_sel_t sel);
      axi_strb_t strb;
      strb = '0;
      for (int i = 0; i < AXI_STRB_W; i++) begin
         strb[i] = ((i / 4) == int'(adr[5:2])) && sel[i % 4];
      end
      return strb;
   endfunction

   task automatic check_quiet();
      compare_err("pcis_awvalid_o", awvalid, 1'b0);
      compare_err("pcis_wvalid_o", wvalid, 1'b0);
      compare_err("pcis_arvalid_o", arvalid, 1'b0);
      compare_err("pcis_bready_o", bready, 1'b0);
      compare_err("pcis_rready_o", rready, 1'b0);
      compare_err("wb_ack_o", wb_ack_o, 1'b0);
      compare_err("wb_err_o", wb_err_o, 1'b0);
   endtask

   //------------------------------------------------
   // AXI beat monitor
   //------------------------------------------------
   always @(posedge clk_out) begin
      if (arst_n_i) begin
         if (misaligned_run && (awvalid || wvalid || arvalid)) begin
            $display("AXI valid raised during a misaligned access at %0t", $time);
            proto_errors++;
         end
         if (aw_wait) begin
            compare_err("pcis_awvalid_o held", awvalid, 1'b1);
            compare_ax("pcis_aw_o held", aw, aw_prev);
         end
         if (ar_wait) begin
            compare_err("pcis_arvalid_o held", arvalid, 1'b1);
            compare_ax("pcis_ar_o held", ar, ar_prev);
         end
         if (w_wait) begin
            compare_err("pcis_wvalid_o held", wvalid, 1'b1);
            compare_strb("pcis_w_o.strb held", w.strb, w_prev.strb);
            compare_data("pcis_w_o lane held", w.data[cur_adr[5:2]*32 +: 32],
                         w_prev.data[cur_adr[5:2]*32 +: 32]);
         end
         if (awvalid) begin
            compare_ax("pcis_aw_o", aw, axi_ax_t'{addr: {32'h0, cur_adr[31:2], 2'b00},
                                                  id: WR_ID, len: '0});
         end
         if (arvalid) begin
            compare_ax("pcis_ar_o", ar, axi_ax_t'{addr: {32'h0, cur_adr[31:2], 2'b00},
                                                  id: RD_ID, len: '0});
         end
         if (wvalid) begin
            compare_strb("pcis_w_o.strb", w.strb, lane_strobe(cur_adr, cur_sel));
            compare_data("pcis_w_o lane", w.data[cur_adr[5:2]*32 +: 32], cur_dat);
            compare_err("pcis_w_o.last", w.last, 1'b1);
         end
         aw_wait = awvalid && !awready;
         ar_wait = arvalid && !arready;
         w_wait  = wvalid && !wready;
         aw_prev = aw;
         ar_prev = ar;
         w_prev  = w;
      end
   end

   // one Wishbone access, called 1 ns after a rising edge
   task automatic wb_access(input logic we, input host_addr_t adr, input host_data_t dat,
                            input host_sel_t sel, output host_data_t rdat,
                            output logic ack, output logic err);
      int cycles;
      cycles         = 0;
      ack            = 1'b0;
      err            = 1'b0;
      rdat           = '0;
      cur_adr        = adr;
      cur_dat        = dat;
      cur_sel        = sel;
      misaligned_run = (adr[1:0] != 2'b00);
      wb_cyc_i       = 1'b1;
      wb_stb_i       = 1'b1;
      wb_we_i        = we;
      wb_adr_i       = adr;
      wb_dat_i       = dat;
      wb_sel_i       = sel;
      while (!ack && !err && cycles < TIMEOUT) begin
         @(negedge clk_out);
         ack  = wb_ack_o;
         err  = wb_err_o;
         rdat = wb_dat_o;
         cycles++;
      end
      if (!ack && !err) begin
         $display("access to %h got neither ack nor err within %0d cycles", adr, TIMEOUT);
         timeout_errors++;
      end
      @(posedge clk_out);
      #1;
      wb_cyc_i       = 1'b0;
      wb_stb_i       = 1'b0;
      misaligned_run = 1'b0;
      @(posedge clk_out);
      #1;
   endtask

   initial begin
      host_data_t rdat;
      host_data_t dat;
      host_sel_t  sel;
      host_addr_t adr;
      logic       ack;
      logic       err;
      seed = 32'ha557_a199;
      {data_errors, proto_errors, timeout_errors} = '0;
      {aw_wait, ar_wait, w_wait, misaligned_run} = '0;
      {wb_cyc_i, wb_stb_i, wb_we_i} = '0;
      wb_adr_i = '0;
      wb_dat_i = '0;
      wb_sel_i = '0;
      cur_adr  = '0;
      cur_dat  = '0;
      cur_sel  = '0;
      for (int i = 0; i < 256; i++) begin
         model[i] = '0;
      end
      arst_n_i = 1'b0;
      repeat (3) begin
         @(negedge clk_out);
         check_quiet();
      end
      @(posedge clk_out);
      #1;
      arst_n_i = 1'b1;
      repeat (2) begin
         @(negedge clk_out);
         check_quiet();
      end
      @(posedge clk_out);
      #1;

      // writes, roughly one in eight to the error region
      for (int i = 0; i < N_ACC; i++) begin
         adr = {(($random(seed) & 7) == 0), 21'($random(seed)), 8'($random(seed)), 2'b00};
         dat = $random(seed);
         sel = 4'($random(seed));
         adr_list[i] = adr;
         wb_access(1'b1, adr, dat, sel, rdat, ack, err);
         compare_err("wb_ack_o on write", ack, !adr[31]);
         compare_err("wb_err_o on write", err, adr[31]);
         if (!adr[31]) begin
            for (int k = 0; k < 4; k++) begin
               if (sel[k]) model[adr[9:2]][k*8 +: 8] = dat[k*8 +: 8];
            end
         end
      end

      // read back the same addresses
      for (int i = 0; i < N_ACC; i++) begin
         adr = adr_list[i];
         wb_access(1'b0, adr, 32'h0, 4'hf, rdat, ack, err);
         compare_err("wb_ack_o on read", ack, !adr[31]);
         compare_err("wb_err_o on read", err, adr[31]);
         if (!adr[31]) compare_data("wb_dat_o", rdat, model[adr[9:2]]);
      end

      // misaligned accesses, both directions
      for (int i = 0; i < 8; i++) begin
         adr = {1'b0, 29'($random(seed)), 2'b00} | host_addr_t'(1 + (i % 3));
         wb_access(i[0], adr, $random(seed), 4'hf, rdat, ack, err);
         compare_err("wb_ack_o on misaligned", ack, 1'b0);
         compare_err("wb_err_o on misaligned", err, 1'b1);
      end

      $display("errors: data %0d, protocol %0d, timeout %0d",
               data_errors, proto_errors, timeout_errors);
      if (data_errors == 0 && proto_errors == 0 && timeout_errors == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* all.f */
+incdir+rtl
rtl/shell_axi_pkg.sv
rtl/shell_host_pkg.sv
rtl/axi_wr_master.sv
rtl/axi_rd_master.sv
rtl/host_access_ctrl.sv
rtl/shell_pcis_bridge.sv
bench/cl_axi_responder.sv
bench/tb_shell_pcis_bridge.sv

/* Makefile */
# Verilator build for the pcis bridge testbench
# override on the command line, e.g. make sim SEED=7 LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_shell_pcis_bridge
LOG       ?= sim.log
SEED      ?= 1
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir

VFLAGS ?= --timing --assert -f $(FILELIST) --top-module $(TOP)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS)

build:
	$(VERILATOR) --binary $(VFLAGS) --Mdir $(OBJ_DIR) -o $(TOP)

sim: build
	./$(OBJ_DIR)/$(TOP) +verilator+seed+$(SEED) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST PASSED" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
